// File: design/boardRegs.sv
`default_nettype none
`include "ticTacToe_consts.svh"

module boardRegs (
	input  logic clk,
	input  logic reset,

	// AXI4-Lite write side
	input  logic [`ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`DATA_W-1:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,

	// AXI4-Lite read side
	input  logic [`ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [`DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,

	// engine side
	input  logic [2*`NUM_CELLS-1:0] board,
	input  ticTacToePkg::gameState state,
	input  logic turn,
	input  logic moveError,
	output logic moveStrobe,
	output logic [`CELL_IDX_W-1:0] moveIndex,
	output logic newGameStrobe
);

	typedef enum logic {
		wrIdle,
		wrResp
	} writePhase;

	typedef enum logic {
		rdIdle,
		rdData
	} readPhase;

	writePhase wrPhase;
	readPhase rdPhase;
	logic wrAccept;
	logic rdAccept;
	logic [`DATA_W-1:0] rdNext;

	// ~~~~~~~~~~~~~~~~~~~~
	// write channel

	assign awready = (wrPhase == wrIdle);
	assign wready = (wrPhase == wrIdle); // address and data taken together
	assign bvalid = (wrPhase == wrResp);
	assign bresp = `RESP_OKAY;
	assign wrAccept = awvalid && wvalid && awready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPhase <= wrIdle;
			moveStrobe <= 1'b0;
			newGameStrobe <= 1'b0;
		end else begin
			// one-cycle pulses high as bvalid rises
			moveStrobe <= wrAccept && (awaddr == `REG_MOVE);
			newGameStrobe <= wrAccept && (awaddr == `REG_CTRL) && wdata[0];
			case (wrPhase)
				wrIdle: begin
					if (wrAccept) begin
						wrPhase <= wrResp;
					end
				end
				wrResp: begin
					if (bready) begin
						wrPhase <= wrIdle;
					end
				end
				default: wrPhase <= wrIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wrAccept) begin
			moveIndex <= wdata[`CELL_IDX_W-1:0]; // legality is the engine's call
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// read channel

	assign arready = (rdPhase == rdIdle);
	assign rvalid = (rdPhase == rdData);
	assign rresp = `RESP_OKAY;
	assign rdAccept = arvalid && arready;

	always_comb begin
		rdNext = '0;
		case (araddr)
			`REG_STATUS: begin
				rdNext[1:0] = state;
				rdNext[2] = turn;
				rdNext[3] = moveError;
			end
			`REG_BOARD: rdNext[2*`NUM_CELLS-1:0] = board;
			default: rdNext = '0; // unmapped reads as zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rdPhase <= rdIdle;
		end else begin
			case (rdPhase)
				rdIdle: begin
					if (rdAccept) begin
						rdPhase <= rdData;
					end
				end
				rdData: begin
					if (rready) begin
						rdPhase <= rdIdle;
					end
				end
				default: rdPhase <= rdIdle;
			endcase
		end
	end

	// held until rready since arready is low meanwhile
	always_ff @(posedge clk) begin
		if (rdAccept) begin
			rdata <= rdNext;
		end
	end

	// response held through back-pressure
	assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid);

	// move and new game never land in the same cycle
	assert property (@(posedge clk) disable iff (reset)
		!(moveStrobe && newGameStrobe));

endmodule

`default_nettype wire

// File: design/cellSelector.sv
`default_nettype none
`include "ticTacToe_consts.svh"

module cellSelector (
	input  logic clk,
	input  logic reset,
	input  logic [2*`NUM_CELLS-1:0] board,
	input  logic [`MATRIX_DIM-1:0][`MATRIX_DIM-1:0] gridPixels,
	output logic [`MATRIX_DIM-1:0][`MATRIX_DIM-1:0] redPixels
);
	import ticTacToePkg::*;

	localparam int glyphSize = 4;

	// top glyph row first with the leftmost pixel in bit 3
	localparam logic [3:0] xGlyph [glyphSize] = '{4'b1001, 4'b0110, 4'b0110, 4'b1001};
	localparam logic [3:0] oGlyph [glyphSize] = '{4'b0110, 4'b1001, 4'b1001, 4'b0110};

	// first pixel row of the glyph per cell row
	// top block is 6 tall so its glyph drops one row
	localparam int glyphTop [3] = '{1, 6, 11};

	// high column of the glyph per cell column
	localparam int glyphLeft [3] = '{14, 9, 4};

	logic [`MATRIX_DIM-1:0][`MATRIX_DIM-1:0] glyphPlane;

	function automatic logic [3:0] glyphRow(input cellState c, input int g);
		case (c)
			cellX: glyphRow = xGlyph[g];
			cellO: glyphRow = oGlyph[g];
			default: glyphRow = 4'b0000; // empty or unused code
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// glyph overlay

	always_comb begin
		glyphPlane = '0;
		for (int k = 0; k < `NUM_CELLS; k++) begin
			for (int g = 0; g < glyphSize; g++) begin
				glyphPlane[glyphTop[k / 3] + g][glyphLeft[k % 3] -: glyphSize] |=
					glyphRow(cellState'(board[2*k +: 2]), g);
			end
		end
	end

	// grid only while in reset
	assign redPixels = reset ? gridPixels : (gridPixels | glyphPlane);

	// only the three cell codes ever reach the display
	assert property (@(posedge clk) disable iff (reset)
		(board & (board >> 1) & {`NUM_CELLS{2'b01}}) == '0);

endmodule

`default_nettype wire

// File: design/gameEngine.sv
`default_nettype none
`include "ticTacToe_consts.svh"

module gameEngine (
	input  logic clk,
	input  logic reset,
	input  logic moveStrobe,
	input  logic [`CELL_IDX_W-1:0] moveIndex,
	input  logic newGameStrobe,
	output logic [2*`NUM_CELLS-1:0] board,
	output ticTacToePkg::gameState state,
	output logic turn,
	output logic moveError
);
	import ticTacToePkg::*;

	// three rows, three columns, two diagonals
	localparam int winLines [8][3] = '{
		'{0, 1, 2}, '{3, 4, 5}, '{6, 7, 8},
		'{0, 3, 6}, '{1, 4, 7}, '{2, 5, 8},
		'{0, 4, 8}, '{2, 4, 6}
	};

	cellState cells [`NUM_CELLS];
	cellState nextCells [`NUM_CELLS];
	gameState nextState;
	logic idxInRange;
	logic cellFree;
	logic legalMove;

	function automatic logic ownsLine(input cellState c [`NUM_CELLS], input cellState who);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (c[winLines[i][0]] == who &&
				c[winLines[i][1]] == who &&
				c[winLines[i][2]] == who) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	function automatic logic boardFull(input cellState c [`NUM_CELLS]);
		logic full;
		full = 1'b1;
		for (int k = 0; k < `NUM_CELLS; k++) begin
			if (c[k] == cellEmpty) begin
				full = 1'b0;
			end
		end
		return full;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// move check

	assign idxInRange = (moveIndex < `CELL_IDX_W'(`NUM_CELLS));
	assign cellFree = idxInRange ? (cells[moveIndex] == cellEmpty) : 1'b0;
	assign legalMove = moveStrobe && cellFree && (state == playing);

	// outcome is judged on the board as it will be after this move
	always_comb begin
		nextCells = cells;
		if (legalMove) begin
			nextCells[moveIndex] = turn ? cellO : cellX;
		end

		if (ownsLine(nextCells, cellX)) begin
			nextState = xWins;
		end else if (ownsLine(nextCells, cellO)) begin
			nextState = oWins;
		end else if (boardFull(nextCells)) begin
			nextState = draw;
		end else begin
			nextState = playing;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// game registers

	always_ff @(posedge clk) begin
		if (reset || newGameStrobe) begin
			cells <= '{default: cellEmpty};
			state <= playing;
			turn <= 1'b0; // X opens
			moveError <= 1'b0;
		end else if (moveStrobe) begin
			cells <= nextCells; // unchanged on a bad move
			state <= nextState;
			turn <= legalMove ? ~turn : turn;
			moveError <= ~legalMove;
		end
	end

	// cell k packed at [2k+1:2k]
	always_comb begin
		for (int k = 0; k < `NUM_CELLS; k++) begin
			board[2*k +: 2] = cells[k];
		end
	end

	// finished game freezes the board until the next new game
	assert property (@(posedge clk) disable iff (reset)
		(state != playing) && !newGameStrobe |=> $stable(board));

endmodule

`default_nettype wire

// File: design/ticTacToe.sv
`default_nettype none
`include "ticTacToe_consts.svh"

module ticTacToe (
	input  logic clk,
	input  logic reset,

	input  logic [`ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`DATA_W-1:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [`DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,

	input  logic [`MATRIX_DIM-1:0][`MATRIX_DIM-1:0] gridPixels,
	output logic [`MATRIX_DIM-1:0][`MATRIX_DIM-1:0] redPixels
);
	import ticTacToePkg::*;

	logic moveStrobe;
	logic [`CELL_IDX_W-1:0] moveIndex;
	logic newGameStrobe;
	logic [2*`NUM_CELLS-1:0] board;
	gameState state;
	logic turn;
	logic moveError;

	boardRegs u_regs (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.board(board), .state(state), .turn(turn), .moveError(moveError),
		.moveStrobe(moveStrobe), .moveIndex(moveIndex), .newGameStrobe(newGameStrobe)
	);

	gameEngine u_engine (
		.clk(clk), .reset(reset),
		.moveStrobe(moveStrobe), .moveIndex(moveIndex), .newGameStrobe(newGameStrobe),
		.board(board), .state(state), .turn(turn), .moveError(moveError)
	);

	// display path, no latency from board
	cellSelector u_cells (
		.clk(clk), .reset(reset),
		.board(board),
		.gridPixels(gridPixels),
		.redPixels(redPixels)
	);

endmodule

`default_nettype wire

// File: design/ticTacToePkg.sv
`default_nettype none

package ticTacToePkg;

	// codes double as glyph select in the cell selector
	typedef enum logic [1:0] {
		cellEmpty = 2'd0,
		cellX     = 2'd1,
		cellO     = 2'd2
	} cellState;

	typedef enum logic [1:0] {
		playing = 2'd0,
		xWins   = 2'd1,
		oWins   = 2'd2,
		draw    = 2'd3
	} gameState;

endpackage

`default_nettype wire

// File: design/ticTacToe_consts.svh
`ifndef TICTACTOE_CONSTS_SVH
`define TICTACTOE_CONSTS_SVH

// board geometry
`define NUM_CELLS   9
`define CELL_IDX_W  4
`define MATRIX_DIM  16

// AXI4-Lite widths
`define ADDR_W      4
`define DATA_W      32
`define RESP_OKAY   2'b00

// register map
`define REG_MOVE    4'h0  // write only, cell index in [3:0]
`define REG_CTRL    4'h4  // write only, bit 0 new game
`define REG_STATUS  4'h8  // read only, {moveError, turn, state}
`define REG_BOARD   4'hC  // read only, cell k in [2k+1:2k]

`endif

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module ticTacToeTb -o simTb; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/simTb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1

// File: tb.f
+incdir+design
design/ticTacToePkg.sv
design/boardRegs.sv
design/gameEngine.sv
design/cellSelector.sv
design/ticTacToe.sv
verif/ticTacToeTb.sv

// File: verif/ticTacToeTb.sv
`default_nettype none
`include "ticTacToe_consts.svh"

module ticTacToeTb;
	timeunit 1ns;
	timeprecision 1ps;
	import ticTacToePkg::*;

	typedef logic [`MATRIX_DIM-1:0][`MATRIX_DIM-1:0] pixelPlane;

	// transactions in the reset, legal, illegal, row, diagonal, draw and stall sequences
	localparam int seqLengths = 2 + 12 + 12 + 21 + 21 + 36 + 7;
	localparam int watchdogCycles = 40 * seqLengths;

	logic clk = 1'b0;
	logic reset;
	logic [`ADDR_W-1:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [`DATA_W-1:0] wdata, rdata;
	logic [1:0] bresp, rresp;
	pixelPlane gridPixels, redPixels;

	int errorCount = 0;
	int protocolErrors = 0;
	logic [31:0] rngState = 32'd79815;

	// reference board kept from the game rules
	cellState refCells [`NUM_CELLS];
	gameState refState;
	logic refTurn;
	logic refError;

	ticTacToe u_dut (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.gridPixels(gridPixels), .redPixels(redPixels)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// helpers

	function automatic logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic void reportViolation(input string what);
		protocolErrors++;
		$display("%s", what);
	endfunction

	function automatic logic sameOwner(input int a, input int b, input int c);
		return refCells[a] != cellEmpty && refCells[a] == refCells[b] && refCells[b] == refCells[c];
	endfunction

	function automatic cellState lineWinner();
		cellState winner;
		winner = cellEmpty;
		for (int i = 0; i < 3; i++) begin
			if (sameOwner(3 * i, 3 * i + 1, 3 * i + 2)) winner = refCells[3 * i]; // row
			if (sameOwner(i, i + 3, i + 6)) winner = refCells[i]; // column
		end
		if (sameOwner(0, 4, 8) || sameOwner(2, 4, 6)) winner = refCells[4];
		return winner;
	endfunction

	function automatic logic [`DATA_W-1:0] expectedBoard();
		logic [`DATA_W-1:0] bits;
		bits = '0;
		for (int k = 0; k < `NUM_CELLS; k++) begin
			bits[2 * k +: 2] = refCells[k];
		end
		return bits;
	endfunction

	function automatic logic [`DATA_W-1:0] expectedStatus();
		return {28'b0, refError, refTurn, refState};
	endfunction

	function automatic pixelPlane expectedPlane();
		pixelPlane plane;
		logic [15:0] glyph;
		int top;
		int hi;
		plane = gridPixels;
		for (int k = 0; k < `NUM_CELLS; k++) begin
			top = (k < 3) ? 1 : (k < 6) ? 6 : 11; // top block is 6 rows tall
			hi = (k % 3 == 0) ? 14 : (k % 3 == 1) ? 9 : 4;
			if (refCells[k] == cellX) glyph = 16'b1001_0110_0110_1001;
			else if (refCells[k] == cellO) glyph = 16'b0110_1001_1001_0110;
			else glyph = '0;
			for (int g = 0; g < 4; g++) begin
				for (int b = 0; b < 4; b++) begin
					if (glyph[15 - 4 * g - b]) plane[top + g][hi - b] = 1'b1;
				end
			end
		end
		return plane;
	endfunction

	task automatic resetModel();
		refCells = '{default: cellEmpty};
		refState = playing;
		refTurn = 1'b0;
		refError = 1'b0;
	endtask

	task automatic applyMove(input int idx);
		cellState winner;
		int filled;
		if (idx < `NUM_CELLS && refState == playing && refCells[idx] == cellEmpty) begin
			refCells[idx] = refTurn ? cellO : cellX;
			refTurn = ~refTurn;
			refError = 1'b0;
			winner = lineWinner();
			filled = 0;
			for (int k = 0; k < `NUM_CELLS; k++) begin
				if (refCells[k] != cellEmpty) filled++;
			end
			if (winner == cellX) refState = xWins;
			else if (winner == cellO) refState = oWins;
			else if (filled == `NUM_CELLS) refState = draw;
		end else begin
			refError = 1'b1; // nothing else moves
		end
	endtask

	task automatic checkWord(input string name, input logic [`DATA_W-1:0] expected,
			input logic [`DATA_W-1:0] actual);
		assert (actual === expected) else begin
			errorCount++;
			$display("mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
		end
	endtask

	task automatic checkPixels(input string name, input pixelPlane expected,
			input pixelPlane actual);
		assert (actual === expected) else begin
			errorCount++;
			$display("mismatch %s: expected 0x%064h, actual 0x%064h", name, expected, actual);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// AXI4-Lite driver

	task automatic axiWrite(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
		int hold;
		hold = int'(nextRandom() % 32'd4);
		@(posedge clk);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		@(negedge clk);
		while (!(awready && wready)) @(negedge clk);
		@(posedge clk); // accepted on this edge
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		repeat (hold) @(posedge clk);
		bready <= 1'b1;
		@(negedge clk);
		while (bvalid) @(negedge clk);
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [`ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data);
		int hold;
		hold = int'(nextRandom() % 32'd4);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		arvalid <= 1'b0;
		repeat (hold) @(posedge clk);
		rready <= 1'b1;
		@(negedge clk);
		data = rdata;
		while (rvalid) @(negedge clk);
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic checkGame(input string name);
		logic [`DATA_W-1:0] word;
		axiRead(`REG_STATUS, word);
		checkWord({name, " status"}, expectedStatus(), word);
		axiRead(`REG_BOARD, word);
		checkWord({name, " board"}, expectedBoard(), word);
		@(negedge clk);
		checkPixels({name, " pixels"}, expectedPlane(), redPixels);
	endtask

	task automatic playMove(input int idx, input string name);
		axiWrite(`REG_MOVE, `DATA_W'(idx));
		applyMove(idx);
		checkGame(name);
	endtask

	task automatic startNewGame(input string name);
		axiWrite(`REG_CTRL, 32'h1);
		resetModel();
		checkGame(name);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// protocol checks

	assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid)
		else reportViolation("bvalid dropped while bready was low");
	assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else reportViolation("read data not held while rready was low");
	assert property (@(posedge clk) disable iff (reset) bvalid |-> !awready && !wready)
		else reportViolation("second write offered while a response waits");
	assert property (@(posedge clk) disable iff (reset) rvalid |-> !arready)
		else reportViolation("second read offered while data waits");
	assert property (@(posedge clk) disable iff (reset) bvalid |-> bresp == `RESP_OKAY)
		else reportViolation("write response code was not OKAY");
	assert property (@(posedge clk) disable iff (reset) rvalid |-> rresp == `RESP_OKAY)
		else reportViolation("read response code was not OKAY");

	// ~~~~~~~~~~~~~~~~~~~~
	// stimulus

	initial begin
		logic [`DATA_W-1:0] word;
		logic [31:0] rnd;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		for (int r = 0; r < `MATRIX_DIM; r++) begin
			rnd = nextRandom();
			gridPixels[r] = rnd[`MATRIX_DIM-1:0];
		end
		resetModel();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkWord("reset handshake", 32'h7, {27'b0, bvalid, rvalid, awready, wready, arready});
		checkGame("reset");

		playMove(4, "legal X4");
		playMove(0, "legal O0");
		playMove(8, "legal X8");
		playMove(2, "legal O2");
		playMove(4, "occupied cell");
		playMove(9, "index 9");
		playMove(15, "index 15");
		playMove(1, "legal after error");

		startNewGame("new game row");
		playMove(0, "row X0");
		playMove(3, "row O3");
		playMove(1, "row X1");
		playMove(4, "row O4");
		playMove(2, "row X2 wins");
		playMove(5, "move after end");

		startNewGame("new game diagonal");
		playMove(1, "diag X1");
		playMove(0, "diag O0");
		playMove(2, "diag X2");
		playMove(4, "diag O4");
		playMove(5, "diag X5");
		playMove(8, "diag O8 wins");

		startNewGame("new game draw");
		playMove(0, "draw X0");
		playMove(1, "draw O1");
		playMove(2, "draw X2");
		playMove(4, "draw O4");
		playMove(3, "draw X3");
		playMove(5, "draw O5");
		playMove(7, "draw X7");
		playMove(6, "draw O6");
		playMove(8, "draw X8 full");
		playMove(4, "move after draw");
		startNewGame("new game clears");

		// board and status must differ so a recaptured word shows up
		playMove(4, "stall setup X4");

		// second read waits behind a stalled one
		@(posedge clk);
		araddr <= `REG_BOARD;
		arvalid <= 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		araddr <= `REG_STATUS;
		repeat (6) @(posedge clk);
		@(negedge clk);
		checkWord("stalled read data", expectedBoard(), rdata);
		checkWord("stalled read handshake", 32'h2, {30'b0, rvalid, arready});
		@(posedge clk);
		rready <= 1'b1;
		@(negedge clk);
		while (rvalid) @(negedge clk);
		while (!rvalid) @(negedge clk);
		word = rdata;
		@(posedge clk);
		arvalid <= 1'b0;
		rready <= 1'b0;
		checkWord("queued read data", expectedStatus(), word);
		axiRead(4'h2, word);
		checkWord("unmapped read 0x2", '0, word);
		axiRead(`REG_CTRL, word);
		checkWord("unmapped read ctrl", '0, word);

		$display("errors: %0d mismatches, %0d protocol violations", errorCount, protocolErrors);
		if (errorCount == 0 && protocolErrors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", watchdogCycles);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
